// File: Makefile
TOP = mips32Tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: logic/execStage.sv
module execStage (
   input  logic                   clk,
   input  logic                   arstN,
   input  mipsPipePkg::ctrlT      ctrlEx,
   input  mipsIsaPkg::aluCtrlT    aluCtrl,
   input  mipsPipePkg::idExDataT  idData,
   output mipsPipePkg::exMemDataT exMem,
   output logic                   zero,
   output mipsIsaPkg::wordT       branchTarget
);

   mipsPipePkg::idExDataT exData;
   mipsIsaPkg::wordT      aluB;
   mipsIsaPkg::wordT      aluResult;
   mipsIsaPkg::wordT      branchSum;
   mipsIsaPkg::regAddrT   writeReg;

   // Data half of ID/EX
   always_ff @(posedge clk) begin
      exData <= idData;
   end

   // Immediate for lw and sw and register otherwise
   assign aluB = ctrlEx.aluSrc ? exData.signExt : exData.readData2;

   always_comb begin
      case (aluCtrl)
         mipsIsaPkg::aluAnd: aluResult = exData.readData1 & aluB;
         mipsIsaPkg::aluOr:  aluResult = exData.readData1 | aluB;
         mipsIsaPkg::aluAdd: aluResult = exData.readData1 + aluB;
         mipsIsaPkg::aluSub: aluResult = exData.readData1 - aluB;
         // Signed compare
         mipsIsaPkg::aluSlt: aluResult = {31'b0, $signed(exData.readData1) < $signed(aluB)};
         default:            aluResult = '0;
      endcase
   end

   // Word offset relative to the next PC
   assign branchSum = exData.pcPlus4 + {exData.signExt[29:0], 2'b00};
   // rd for R-type and rt for lw
   assign writeReg  = ctrlEx.regDst ? exData.rd : exData.rt;

   // EX/MEM
   always_ff @(posedge clk) begin
      exMem.aluResult <= aluResult;
      exMem.writeData <= exData.readData2;
      exMem.writeReg  <= writeReg;
      branchTarget    <= branchSum;
   end

   // Zero flag of the ALU result
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         zero <= 1'b0;
      end else begin
         zero <= aluResult == '0;
      end
   end

endmodule

// File: logic/fetchStage.sv
module fetchStage (
   input  logic             clk,
   input  logic             arstN,
   input  logic             pcSrc,
   input  mipsIsaPkg::wordT branchTarget,
   input  mipsIsaPkg::wordT instr,
   output mipsIsaPkg::wordT imemAddr,
   output mipsIsaPkg::wordT instrId,
   output mipsIsaPkg::wordT pcPlus4Id
);

   mipsIsaPkg::wordT pc;
   mipsIsaPkg::wordT pcPlus4;
   mipsIsaPkg::wordT nextPc;

   assign pcPlus4  = pc + 32'd4;
   // Taken beq from MEM overrides the sequential fetch
   assign nextPc   = pcSrc ? branchTarget : pcPlus4;
   assign imemAddr = pc;

   // PC and instruction half of IF/ID
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc      <= '0;
         // All-zero word decodes as nop
         instrId <= '0;
      end else begin
         pc      <= nextPc;
         instrId <= instr;
      end
   end

   always_ff @(posedge clk) begin
      pcPlus4Id <= pcPlus4;
   end

   // Branch targets from EX must keep the fetch word-aligned
   pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
      else $error("PC not word-aligned: %h", pc);

endmodule

// File: logic/memStage.sv
module memStage (
   input  logic                   clk,
   input  logic                   arstN,
   input  mipsPipePkg::ctrlT      ctrlMem,
   input  mipsPipePkg::ctrlT      ctrlWb,
   input  mipsPipePkg::exMemDataT exMem,
   input  logic                   zero,
   output logic                   pcSrc,
   output mipsPipePkg::wbT        wb
);

   mipsIsaPkg::wordT    dataMem [mipsIsaPkg::dataMemWords];
   logic [mipsIsaPkg::dataMemAddrBits-1:0] wordAddr;
   mipsIsaPkg::wordT    readData;
   mipsIsaPkg::wordT    readDataWb;
   mipsIsaPkg::wordT    aluResultWb;
   mipsIsaPkg::regAddrT writeRegWb;

   // Word index with the byte offset dropped
   assign wordAddr = exMem.aluResult[mipsIsaPkg::dataMemAddrBits+1:2];
   assign readData = ctrlMem.memRead ? dataMem[wordAddr] : '0;
   // Taken beq
   assign pcSrc    = ctrlMem.branch & zero;

   // Unwritten words load as 0
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < mipsIsaPkg::dataMemWords; i++) dataMem[i] <= '0;
      end else if (ctrlMem.memWrite) begin
         dataMem[wordAddr] <= exMem.writeData;
      end
   end

   // MEM/WB
   always_ff @(posedge clk) begin
      readDataWb  <= readData;
      aluResultWb <= exMem.aluResult;
      writeRegWb  <= exMem.writeReg;
   end

   // Write-back select
   assign wb.writeEnable = ctrlWb.regWrite;
   assign wb.writeReg    = writeRegWb;
   assign wb.writeData   = ctrlWb.memToReg ? readDataWb : aluResultWb;

endmodule

// File: logic/mips32.sv
module mips32 (
   input  logic             clk,
   input  logic             arstN,
   output mipsIsaPkg::wordT imemAddr,
   input  mipsIsaPkg::wordT instr,
   output mipsPipePkg::wbT  wb
);

   mipsIsaPkg::wordT      instrId;
   mipsIsaPkg::wordT      pcPlus4Id;
   mipsIsaPkg::wordT      readData1;
   mipsIsaPkg::wordT      readData2;
   mipsIsaPkg::wordT      branchTarget;
   logic                  pcSrc;
   logic                  zero;
   mipsPipePkg::ctrlT     ctrlEx;
   mipsPipePkg::ctrlT     ctrlMem;
   mipsPipePkg::ctrlT     ctrlWb;
   mipsIsaPkg::aluCtrlT   aluCtrl;
   mipsPipePkg::idExDataT idData;
   mipsPipePkg::exMemDataT exMem;

   fetchStage u_fetchStage (
      .clk(clk), .arstN(arstN), .pcSrc(pcSrc), .branchTarget(branchTarget),
      .instr(instr), .imemAddr(imemAddr), .instrId(instrId), .pcPlus4Id(pcPlus4Id)
   );

   // Register numbers straight from the ID word
   regFile u_regFile (
      .clk(clk), .arstN(arstN),
      .readAddr1(instrId[mipsIsaPkg::rsPos +: mipsIsaPkg::regBits]),
      .readAddr2(instrId[mipsIsaPkg::rtPos +: mipsIsaPkg::regBits]),
      .readData1(readData1), .readData2(readData2), .wb(wb)
   );

   pipeControl u_pipeControl (
      .clk(clk), .arstN(arstN),
      .opcode(instrId[mipsIsaPkg::opPos +: mipsIsaPkg::opBits]),
      .funct(instrId[mipsIsaPkg::functPos +: mipsIsaPkg::opBits]),
      .ctrlEx(ctrlEx), .aluCtrl(aluCtrl), .ctrlMem(ctrlMem), .ctrlWb(ctrlWb)
   );

   // ID values for EX with the immediate sign-extended
   assign idData.pcPlus4   = pcPlus4Id;
   assign idData.readData1 = readData1;
   assign idData.readData2 = readData2;
   assign idData.signExt   = {{(32 - mipsIsaPkg::immBits){instrId[mipsIsaPkg::immBits-1]}},
                              instrId[mipsIsaPkg::immBits-1:0]};
   assign idData.rt        = instrId[mipsIsaPkg::rtPos +: mipsIsaPkg::regBits];
   assign idData.rd        = instrId[mipsIsaPkg::rdPos +: mipsIsaPkg::regBits];

   execStage u_execStage (
      .clk(clk), .arstN(arstN), .ctrlEx(ctrlEx), .aluCtrl(aluCtrl), .idData(idData),
      .exMem(exMem), .zero(zero), .branchTarget(branchTarget)
   );

   memStage u_memStage (
      .clk(clk), .arstN(arstN), .ctrlMem(ctrlMem), .ctrlWb(ctrlWb), .exMem(exMem),
      .zero(zero), .pcSrc(pcSrc), .wb(wb)
   );

endmodule

// File: logic/mipsIsaPkg.sv
package mipsIsaPkg;

   // Field widths of the instruction word
   localparam int opBits  = 6;
   localparam int regBits = 5;
   localparam int immBits = 16;

   // Field positions counted from bit 0
   localparam int opPos    = 26;
   localparam int rsPos    = 21;
   localparam int rtPos    = 16;
   localparam int rdPos    = 11;
   localparam int functPos = 0;

   // Data word or byte address
   typedef logic [31:0] wordT;
   typedef logic [regBits-1:0] regAddrT;
   // Operation select of the ALU
   typedef logic [3:0] aluCtrlT;
   // Class handed from the main decoder to the ALU decoder
   typedef logic [1:0] aluOpT;

   localparam aluOpT aluOpMem    = 2'b00;
   localparam aluOpT aluOpBranch = 2'b01;
   localparam aluOpT aluOpR      = 2'b10;

   // Primary opcodes
   localparam logic [opBits-1:0] opR   = 6'h00;
   localparam logic [opBits-1:0] opLw  = 6'h23;
   localparam logic [opBits-1:0] opSw  = 6'h2B;
   localparam logic [opBits-1:0] opBeq = 6'h04;

   // R-type funct codes
   localparam logic [opBits-1:0] fnAdd = 6'h20;
   localparam logic [opBits-1:0] fnSub = 6'h22;
   localparam logic [opBits-1:0] fnAnd = 6'h24;
   localparam logic [opBits-1:0] fnOr  = 6'h25;
   localparam logic [opBits-1:0] fnSlt = 6'h2A;

   // Textbook ALU encodings
   localparam aluCtrlT aluAnd = 4'b0000;
   localparam aluCtrlT aluOr  = 4'b0001;
   localparam aluCtrlT aluAdd = 4'b0010;
   localparam aluCtrlT aluSub = 4'b0110;
   localparam aluCtrlT aluSlt = 4'b0111;

   // Data memory size in words
   localparam int dataMemWords    = 64;
   localparam int dataMemAddrBits = $clog2(dataMemWords);

endpackage

// File: logic/mipsPipePkg.sv
package mipsPipePkg;

   // Control bundle made in ID and carried down the pipe
   typedef struct packed {
      // WB group
      logic              regWrite;
      logic              memToReg;
      // MEM group
      logic              branch;
      logic              memRead;
      logic              memWrite;
      // EX group
      logic              regDst;
      logic              aluSrc;
      mipsIsaPkg::aluOpT aluOp;
   } ctrlT;

   // Values gathered in ID for the EX stage
   typedef struct packed {
      mipsIsaPkg::wordT    pcPlus4;
      mipsIsaPkg::wordT    readData1;
      mipsIsaPkg::wordT    readData2;
      // Also carries funct in its low bits
      mipsIsaPkg::wordT    signExt;
      mipsIsaPkg::regAddrT rt;
      mipsIsaPkg::regAddrT rd;
   } idExDataT;

   // Data half of EX/MEM
   typedef struct packed {
      mipsIsaPkg::wordT    aluResult;
      // Store data taken from rt
      mipsIsaPkg::wordT    writeData;
      mipsIsaPkg::regAddrT writeReg;
   } exMemDataT;

   // Register write request and probe record
   typedef struct packed {
      logic                writeEnable;
      mipsIsaPkg::regAddrT writeReg;
      mipsIsaPkg::wordT    writeData;
   } wbT;

endpackage

// File: logic/pipeControl.sv
module pipeControl (
   input  logic                clk,
   input  logic                arstN,
   input  logic [5:0]          opcode,
   input  logic [5:0]          funct,
   output mipsPipePkg::ctrlT   ctrlEx,
   output mipsIsaPkg::aluCtrlT aluCtrl,
   output mipsPipePkg::ctrlT   ctrlMem,
   output mipsPipePkg::ctrlT   ctrlWb
);

   mipsPipePkg::ctrlT ctrlId;
   logic [5:0]        functEx;

   // Main decoder in ID
   always_comb begin
      ctrlId = '0;
      case (opcode)
         mipsIsaPkg::opR: begin
            // Unsupported functs such as the nop word stay silent
            if (funct inside {mipsIsaPkg::fnAdd, mipsIsaPkg::fnSub, mipsIsaPkg::fnAnd,
                              mipsIsaPkg::fnOr, mipsIsaPkg::fnSlt}) begin
               ctrlId.regWrite = 1'b1;
               ctrlId.regDst   = 1'b1;
               ctrlId.aluOp    = mipsIsaPkg::aluOpR;
            end
         end
         mipsIsaPkg::opLw: begin
            ctrlId.regWrite = 1'b1;
            ctrlId.memToReg = 1'b1;
            ctrlId.memRead  = 1'b1;
            ctrlId.aluSrc   = 1'b1;
            ctrlId.aluOp    = mipsIsaPkg::aluOpMem;
         end
         mipsIsaPkg::opSw: begin
            ctrlId.memWrite = 1'b1;
            ctrlId.aluSrc   = 1'b1;
            ctrlId.aluOp    = mipsIsaPkg::aluOpMem;
         end
         mipsIsaPkg::opBeq: begin
            ctrlId.branch = 1'b1;
            ctrlId.aluOp  = mipsIsaPkg::aluOpBranch;
         end
         default: ctrlId = '0;
      endcase
   end

   // Second-level ALU decoder in EX
   always_comb begin
      case (ctrlEx.aluOp)
         mipsIsaPkg::aluOpMem:    aluCtrl = mipsIsaPkg::aluAdd;
         mipsIsaPkg::aluOpBranch: aluCtrl = mipsIsaPkg::aluSub;
         default: begin
            case (functEx)
               mipsIsaPkg::fnSub: aluCtrl = mipsIsaPkg::aluSub;
               mipsIsaPkg::fnAnd: aluCtrl = mipsIsaPkg::aluAnd;
               mipsIsaPkg::fnOr:  aluCtrl = mipsIsaPkg::aluOr;
               mipsIsaPkg::fnSlt: aluCtrl = mipsIsaPkg::aluSlt;
               default:           aluCtrl = mipsIsaPkg::aluAdd;
            endcase
         end
      endcase
   end

   // ID/EX, EX/MEM and MEM/WB copies of the bundle
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         ctrlEx  <= '0;
         ctrlMem <= '0;
         ctrlWb  <= '0;
      end else begin
         ctrlEx  <= ctrlId;
         ctrlMem <= ctrlEx;
         ctrlWb  <= ctrlMem;
      end
   end

   always_ff @(posedge clk) begin
      functEx <= funct;
   end

   // A load and a store never share a MEM slot
   memExclusive: assert property (@(posedge clk) disable iff (!arstN)
      !(ctrlMem.memRead && ctrlMem.memWrite))
      else $error("memRead and memWrite both set in MEM");

endmodule

// File: logic/regFile.sv
module regFile (
   input  logic                clk,
   input  logic                arstN,
   input  mipsIsaPkg::regAddrT readAddr1,
   input  mipsIsaPkg::regAddrT readAddr2,
   output mipsIsaPkg::wordT    readData1,
   output mipsIsaPkg::wordT    readData2,
   input  mipsPipePkg::wbT     wb
);

   mipsIsaPkg::wordT regs [32];

   // Read port with write-through from WB
   function automatic mipsIsaPkg::wordT readPort(input mipsIsaPkg::regAddrT addr);
      // Write-through skips r0 so it keeps reading as zero
      if (wb.writeEnable && wb.writeReg != '0 && wb.writeReg == addr) return wb.writeData;
      return regs[addr];
   endfunction

   always_comb begin
      readData1 = readPort(readAddr1);
      readData2 = readPort(readAddr2);
   end

   // Writes to r0 are dropped
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 32; i++) regs[i] <= '0;
      end else if (wb.writeEnable && wb.writeReg != '0) begin
         regs[wb.writeReg] <= wb.writeData;
      end
   end

   // r0 reads as zero on both ports
   r0ReadsZero: assert property (@(posedge clk) disable iff (!arstN)
      (readAddr1 != '0 || readData1 == '0) && (readAddr2 != '0 || readData2 == '0))
      else $error("r0 read back nonzero");

endmodule

// File: sim.f
logic/mipsIsaPkg.sv
logic/mipsPipePkg.sv
logic/fetchStage.sv
logic/pipeControl.sv
logic/regFile.sv
logic/execStage.sv
logic/memStage.sv
logic/mips32.sv
testbench/tbClockGen.sv
testbench/mips32Tb.sv

// File: testbench/mips32Tb.sv
module mips32Tb;

   localparam int clkPeriod   = 40;
   // Quiet cycles after the last expected record catch extra pulses
   localparam int drainCycles = 8;

   logic                clk;
   logic                arstN;
   mipsIsaPkg::wordT    imemAddr;
   mipsIsaPkg::wordT    instr;
   mipsPipePkg::wbT     wb;

   // Program image, expected write-backs and beq fetch expectations
   mipsIsaPkg::wordT    progWords [$];
   mipsPipePkg::wbT     expWb [$];
   mipsIsaPkg::wordT    brAddr [$];
   mipsIsaPkg::wordT    brFetch [$];
   // Pending fetch checks with due cycle and address
   int                  dueCycle [$];
   mipsIsaPkg::wordT    dueFetch [$];

   int                  valueErrors  = 0;
   int                  otherErrors  = 0;
   int                  wIdx         = 0;
   int                  brSeen       = 0;
   int                  cycle        = 0;
   int                  tail         = 0;
   int                  watchdogTime = 0;
   bit                  loaded       = 1'b0;

   tbClockGen #(.period(clkPeriod)) u_tbClockGen (.clk(clk));

   mips32 u_mips32 (
      .clk(clk), .arstN(arstN), .imemAddr(imemAddr), .instr(instr), .wb(wb)
   );

   // Parses P, W and B records and skips comment lines
   function automatic bit readInput();
      int                  fd;
      string               line;
      mipsIsaPkg::wordT    word;
      mipsIsaPkg::wordT    target;
      mipsIsaPkg::regAddrT regNum;
      mipsPipePkg::wbT     rec;
      fd = $fopen("testbench/mipsInput.txt", "r");
      if (fd == 0) return 1'b0;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 0) begin
            if (line.getc(0) == "P" && $sscanf(line, "P %h", word) == 1) begin
               progWords.push_back(word);
            end else if (line.getc(0) == "W" && $sscanf(line, "W %d %h", regNum, word) == 2) begin
               rec.writeEnable = 1'b1;
               rec.writeReg    = regNum;
               rec.writeData   = word;
               expWb.push_back(rec);
            end else if (line.getc(0) == "B" && $sscanf(line, "B %h %h", word, target) == 2) begin
               brAddr.push_back(word);
               brFetch.push_back(target);
            end
         end
      end
      $fclose(fd);
      return 1'b1;
   endfunction

   task automatic checkWb(input mipsPipePkg::wbT actual, input mipsPipePkg::wbT expected,
                          input string what);
      if (actual !== expected) begin
         valueErrors++;
         $display("** Error at %0t: %s got en=%b r%0d=%h, expected en=%b r%0d=%h", $time, what,
                  actual.writeEnable, actual.writeReg, actual.writeData,
                  expected.writeEnable, expected.writeReg, expected.writeData);
      end
   endtask

   task automatic checkFetch(input mipsIsaPkg::wordT actual, input mipsIsaPkg::wordT expected,
                             input string what);
      if (actual !== expected) begin
         valueErrors++;
         $display("** Error at %0t: %s got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   // Instruction memory model serving nop past the end of the image
   task automatic serveFetch();
      int idx;
      idx = int'(imemAddr[31:2]);
      for (int i = 0; i < brAddr.size(); i++) begin
         if (brAddr[i] == imemAddr) begin
            // Redirect shows up four fetches later
            dueCycle.push_back(cycle + 4);
            dueFetch.push_back(brFetch[i]);
            brSeen++;
         end
      end
      instr = (idx < progWords.size()) ? progWords[idx] : '0;
   endtask

   task automatic sampleOutputs();
      if (dueCycle.size() > 0 && dueCycle[0] == cycle) begin
         checkFetch(imemAddr, dueFetch[0], "fetch after beq");
         void'(dueCycle.pop_front());
         void'(dueFetch.pop_front());
      end
      if (wb.writeEnable !== 1'b0) begin
         if (wIdx < expWb.size()) begin
            checkWb(wb, expWb[wIdx], "write-back");
            wIdx++;
         end else begin
            valueErrors++;
            $display("** Error at %0t: unexpected write-back to r%0d", $time, wb.writeReg);
         end
      end
   endtask

   task automatic finishRun();
      if (wIdx < expWb.size()) begin
         otherErrors++;
         $display("%0d expected write-backs never appeared", expWb.size() - wIdx);
      end
      if (brSeen < brAddr.size()) begin
         otherErrors++;
         $display("%0d listed beq addresses were never fetched", brAddr.size() - brSeen);
      end
      $display("Error count: %0d value errors, %0d other errors", valueErrors, otherErrors);
      if (valueErrors + otherErrors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   endtask

   initial begin
      bit loadOk;
      arstN  = 1'b0;
      instr  = '0;
      loadOk = readInput();
      if (!loadOk) begin
         otherErrors++;
         $display("Could not open testbench/mipsInput.txt");
         finishRun();
      end else begin
         watchdogTime = clkPeriod * (progWords.size() + expWb.size() + 20);
         loaded = 1'b1;
         // No write-back allowed during the two reset cycles
         repeat (2) begin
            @(negedge clk);
            if (wb.writeEnable !== 1'b0) begin
               valueErrors++;
               $display("** Error at %0t: write-back during reset", $time);
            end
         end
         arstN = 1'b1;
         checkFetch(imemAddr, '0, "first fetch after reset");
         while (tail < drainCycles) begin
            serveFetch();
            @(negedge clk);
            cycle++;
            sampleOutputs();
            if (wIdx == expWb.size() && dueCycle.size() == 0) tail++;
         end
         finishRun();
      end
   end

   // Watchdog sized from the program and record counts
   initial begin
      wait (loaded);
      #(watchdogTime);
      otherErrors++;
      $display("Watchdog expired with %0d of %0d write-backs seen", wIdx, expWb.size());
      finishRun();
   end

endmodule

// File: testbench/mipsInput.txt
# P <instruction hex> | W <register> <write data hex> | B <beq address hex> <fetch address 4 later>
# Registers and data memory clear on reset and no opcode brings data in, so every result is 0
P 8C010000  # 00 lw  r1, 0(r0)
P 8C020004  # 04 lw  r2, 4(r0)
P 00000000  # 08 nop
P AC010008  # 0C sw  r1, 8(r0)
P 00221820  # 10 add r3, r1, r2
P 00222022  # 14 sub r4, r1, r2
P 00222824  # 18 and r5, r1, r2
P 8C060008  # 1C lw  r6, 8(r0), reads the word stored at 0C
P 00223825  # 20 or  r7, r1, r2
P 0022402A  # 24 slt r8, r1, r2
P 8C0900FC  # 28 lw  r9, 252(r0), word never written
P 00220020  # 2C add r0, r1, r2
P 00000000  # 30 nop
P 00000000  # 34 nop
P 00005020  # 38 add r10, r0, r0
P 10000004  # 3C beq r0, r0, +4 to 50
P 00005820  # 40 add r11, r0, r0, delay slot
P 00000000  # 44 nop
P 00000000  # 48 nop
P 00006020  # 4C add r12, r0, r0, skipped
P 00006820  # 50 add r13, r0, r0
W 1 00000000
W 2 00000000
W 3 00000000
W 4 00000000
W 5 00000000
W 6 00000000
W 7 00000000
W 8 00000000
W 9 00000000
W 0 00000000
W 10 00000000
W 11 00000000
W 13 00000000
B 0000003C 00000050

// File: testbench/tbClockGen.sv
module tbClockGen #(
   parameter int period = 40
) (
   output logic clk
);

   // Low at time 0 with the first rising edge half a period in
   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

endmodule
